// ==== filelist.f ====
src/periph_pkg.sv
src/periph_decoder.sv
src/irq_controller.sv
src/periph_timer.sv
src/uart_tx.sv
src/periph_top.sv
verification/tb_periph.sv

// ==== verification/tb_periph.sv ====
// Runs periph_top with both timers and the UART included; stimulus 2 ns after each rising edge
`timescale 1ns/1ps
`default_nettype none

module tb_periph;
    import periph_pkg::*;

    localparam int BusTimeout = 8;   // Cycles to wait for ready

    logic                    clk;
    logic                    rst_n;
    logic                    bus_req;
    logic                    bus_we;
    logic [BusAddrWidth-1:0] bus_addr;
    logic [BusDataWidth-1:0] bus_wdata;
    logic [BusDataWidth-1:0] bus_rdata;
    logic                    bus_ready;
    logic                    bus_err;
    logic [3:0]              ext_irq;
    logic                    irq;
    logic                    tx;
    int                      error_count;
    int                      timeout_count;

    periph_top #(.TimerCnt(2), .InclUart(1), .InclTimer(1)) i_dut (
        .clk_i(clk), .rst_n_i(rst_n), .bus_req_i(bus_req), .bus_we_i(bus_we),
        .bus_addr_i(bus_addr), .bus_wdata_i(bus_wdata), .bus_rdata_o(bus_rdata),
        .bus_ready_o(bus_ready), .bus_err_o(bus_err), .ext_irq_i(ext_irq),
        .irq_o(irq), .tx_o(tx)
    );

    always #10 clk = ~clk;

    // ------------------------------------------------------------------------
    // Bus protocol checks
    // ------------------------------------------------------------------------
    a_ready_after_accept: assert property (@(posedge clk) disable iff (!rst_n)
        (bus_req && !bus_ready) |=> bus_ready) else begin
        error_count++;
        $display("Bus ready did not arrive one cycle after an accepted request");
    end

    a_ready_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        bus_ready |=> !bus_ready) else begin
        error_count++;
        $display("Bus ready stayed high for more than one cycle");
    end

    a_err_only_with_ready: assert property (@(posedge clk) disable iff (!rst_n)
        bus_err |-> bus_ready) else begin
        error_count++;
        $display("Bus error flag was high without ready");
    end

    task automatic check_equal(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            error_count++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    function automatic logic [BusAddrWidth-1:0] reg_addr(input int slot, input int word);
        return BusAddrWidth'((slot << SlotShift) | (word << 2));
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    // Called 2 ns after an edge, returns 2 ns after the ready edge
    task automatic bus_xfer(input logic we, input logic [BusAddrWidth-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
        int waited;
        bus_req   = 1'b1;
        bus_we    = we;
        bus_addr  = addr;
        bus_wdata = wdata;
        @(posedge clk);
        #2;
        waited = 1;
        while (!bus_ready && waited < BusTimeout) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (!bus_ready) begin
            timeout_count++;
            $display("Timed out waiting for bus ready at address %h", addr);
        end
        rdata   = bus_rdata;
        err     = bus_err;
        bus_req = 1'b0;
        bus_we  = 1'b0;
    endtask

    task automatic bus_write(input logic [BusAddrWidth-1:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        bus_xfer(1'b1, addr, data, rdata, err);
        check_equal("write error flag", 32'(0), 32'(err));
    endtask

    task automatic bus_read(input logic [BusAddrWidth-1:0] addr, output logic [31:0] data);
        logic err;
        bus_xfer(1'b0, addr, '0, data, err);
        check_equal("read error flag", 32'(0), 32'(err));
    endtask

    task automatic check_read(input string name, input logic [BusAddrWidth-1:0] addr,
                              input logic [31:0] exp);
        logic [31:0] data;
        bus_read(addr, data);
        check_equal(name, exp, data);
    endtask

    task automatic check_absent(input string name, input int slot);
        logic [31:0] data;
        logic        err;
        bus_xfer(1'b0, reg_addr(slot, 2), '0, data, err);
        check_equal({name, " read error flag"}, 32'(1), 32'(err));
        check_equal({name, " read data"}, ErrorFill, data);
        bus_xfer(1'b1, reg_addr(slot, 2), 32'h5555_aaaa, data, err);
        check_equal({name, " write error flag"}, 32'(1), 32'(err));
        bus_xfer(1'b1, reg_addr(slot, 0), 32'h5555_aaaa, data, err);
        check_equal({name, " word 0 write error flag"}, 32'(1), 32'(err));
    endtask

    // Samples each bit at its centre once the line falls
    task automatic sample_frame(input int div, input logic [7:0] exp_byte);
        logic [7:0] rebuilt;
        int         waited;
        waited = 0;
        while (tx && waited < 64) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (tx) begin
            timeout_count++;
            $display("Timed out waiting for the UART start bit");
        end else begin
            #(div * 10 - 2);
            check_equal("uart start bit", 32'(0), 32'(tx));
            for (int i = 0; i < 8; i++) begin
                #(div * 20);
                rebuilt[i] = tx;
            end
            #(div * 20);
            check_equal("uart stop bit", 32'(1), 32'(tx));
            check_equal("uart byte", 32'(exp_byte), 32'(rebuilt));
        end
    endtask

    initial begin
        logic [31:0] data;
        int          chan;
        int          cmp;
        int          div;
        int          polls;
        logic [7:0]  tx_byte;

        clk = 0;
        rst_n = 0;
        bus_req = 0;
        bus_we = 0;
        bus_addr = '0;
        bus_wdata = '0;
        ext_irq = '0;
        error_count = 0;
        timeout_count = 0;
        void'($urandom(32'h8ab0));
        wait_cycles(8);
        rst_n = 1'b1;

        // Reset state
        wait_cycles(1);
        check_equal("reset irq", 32'(0), 32'(irq));
        check_equal("reset ready", 32'(0), 32'(bus_ready));
        check_equal("reset tx line", 32'(1), 32'(tx));

        // ---------------------------------------------------------------------------
        // Readback and absent slots
        // ---------------------------------------------------------------------------
        bus_write(reg_addr(SLOT_TIMER, 0 * 4 + int'(TMR_COMPARE)), 32'h0000_a5a5);
        bus_write(reg_addr(SLOT_TIMER, 1 * 4 + int'(TMR_COMPARE)), 32'h1234_0f0f);
        bus_write(reg_addr(SLOT_UART, int'(UART_DIV)), 32'h0000_0123);
        check_read("timer0 compare", reg_addr(SLOT_TIMER, int'(TMR_COMPARE)), 32'h0000_a5a5);
        check_read("timer1 compare", reg_addr(SLOT_TIMER, 4 + int'(TMR_COMPARE)), 32'h1234_0f0f);
        check_read("uart div", reg_addr(SLOT_UART, int'(UART_DIV)), 32'h0000_0123);
        check_absent("spi slot", int'(SLOT_SPI));
        check_absent("eth slot", int'(SLOT_ETH));
        check_absent("slot 9", 9);
        check_read("timer0 compare after absent writes",
                   reg_addr(SLOT_TIMER, int'(TMR_COMPARE)), 32'h0000_a5a5);
        check_read("uart div after absent writes", reg_addr(SLOT_UART, int'(UART_DIV)),
                   32'h0000_0123);

        // Timer match on a random channel
        chan = $urandom % 2;
        cmp  = $urandom % 64;
        bus_write(reg_addr(SLOT_TIMER, chan * 4 + int'(TMR_COMPARE)), 32'(cmp));
        bus_write(reg_addr(SLOT_TIMER, chan * 4 + int'(TMR_COUNT)), 32'h0);
        bus_write(reg_addr(SLOT_TIMER, chan * 4 + int'(TMR_CTRL)), 32'h1);
        polls = 0;
        data  = '0;
        while (!data[0] && polls < 4 * cmp + 16) begin
            bus_read(reg_addr(SLOT_TIMER, chan * 4 + int'(TMR_STATUS)), data);
            polls++;
        end
        if (!data[0]) begin
            timeout_count++;
            $display("Timed out waiting for the timer match on channel %0d", chan);
        end
        bus_read(reg_addr(SLOT_IRQ, int'(IRQ_PENDING)), data);
        check_equal("timer pending bit", 32'(1), 32'(data[2 + chan]));
        bus_write(reg_addr(SLOT_TIMER, chan * 4 + int'(TMR_CTRL)), 32'h0);
        bus_write(reg_addr(SLOT_TIMER, chan * 4 + int'(TMR_STATUS)), 32'h1);
        check_read("timer match cleared", reg_addr(SLOT_TIMER, chan * 4 + int'(TMR_STATUS)),
                   32'h0);

        // ---------------------------------------------------------------------------
        // Priority claim on the external lines, sources 4 to 7
        // ---------------------------------------------------------------------------
        bus_write(reg_addr(SLOT_IRQ, int'(IRQ_PRIO4)), 32'd3);
        bus_write(reg_addr(SLOT_IRQ, int'(IRQ_PRIO5)), 32'd6);
        bus_write(reg_addr(SLOT_IRQ, int'(IRQ_PRIO6)), 32'd6);
        bus_write(reg_addr(SLOT_IRQ, int'(IRQ_PRIO7)), 32'd2);
        bus_write(reg_addr(SLOT_IRQ, int'(IRQ_THRESHOLD)), 32'd6);
        bus_write(reg_addr(SLOT_IRQ, int'(IRQ_ENABLE)), 32'h0000_00f0);
        ext_irq = 4'hf;
        wait_cycles(2);
        check_equal("irq low at threshold", 32'(0), 32'(irq));
        check_read("claim at threshold", reg_addr(SLOT_IRQ, int'(IRQ_CLAIM)), 32'd0);
        bus_write(reg_addr(SLOT_IRQ, int'(IRQ_THRESHOLD)), 32'd2);
        wait_cycles(2);
        check_equal("irq above threshold", 32'(1), 32'(irq));
        check_read("claim tie lowest id", reg_addr(SLOT_IRQ, int'(IRQ_CLAIM)), 32'd5);
        check_read("claim skips in service", reg_addr(SLOT_IRQ, int'(IRQ_CLAIM)), 32'd6);
        bus_write(reg_addr(SLOT_IRQ, int'(IRQ_CLAIM)), 32'd5);
        check_read("claim after complete", reg_addr(SLOT_IRQ, int'(IRQ_CLAIM)), 32'd5);
        check_read("claim lower priority", reg_addr(SLOT_IRQ, int'(IRQ_CLAIM)), 32'd4);
        check_read("claim none left", reg_addr(SLOT_IRQ, int'(IRQ_CLAIM)), 32'd0);
        wait_cycles(2);
        check_equal("irq low with none left", 32'(0), 32'(irq));
        for (int id = 4; id <= 6; id++) begin
            bus_write(reg_addr(SLOT_IRQ, int'(IRQ_CLAIM)), 32'(id));
        end
        ext_irq = 4'h0;
        bus_write(reg_addr(SLOT_IRQ, int'(IRQ_ENABLE)), 32'h0);
        bus_write(reg_addr(SLOT_IRQ, int'(IRQ_THRESHOLD)), 32'd0);

        // UART frame with a busy read while the line is sampled
        div     = 2 + $urandom % 7;
        tx_byte = 8'($urandom);
        bus_write(reg_addr(SLOT_UART, int'(UART_DIV)), 32'(div));
        fork
            sample_frame(div, tx_byte);
            begin
                bus_write(reg_addr(SLOT_UART, int'(UART_TXDATA)), 32'(tx_byte));
                check_read("uart busy in frame", reg_addr(SLOT_UART, int'(UART_STATUS)),
                           32'h1);
            end
        join
        @(posedge clk);
        #2;
        polls = 0;
        data  = 32'h1;
        while (data[0] && polls < 16) begin
            bus_read(reg_addr(SLOT_UART, int'(UART_STATUS)), data);
            polls++;
        end
        if (data[0]) begin
            timeout_count++;
            $display("Timed out waiting for the UART to go idle");
        end
        bus_write(reg_addr(SLOT_UART, int'(UART_IE)), 32'h1);
        bus_write(reg_addr(SLOT_IRQ, int'(IRQ_PRIO1)), 32'd5);
        bus_write(reg_addr(SLOT_IRQ, int'(IRQ_ENABLE)), 32'h0000_0002);
        wait_cycles(2);
        check_equal("uart irq", 32'(1), 32'(irq));

        $display("Checks failed: %0d, timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/periph_top.sv ====
// One bus master, one interrupt target; excluded peers answer with error and hold their lines idle
`timescale 1ns/1ps
`default_nettype none

module periph_top #(
    parameter int TimerCnt  = 2,
    parameter bit InclUart  = 1,
    parameter bit InclTimer = 1
) (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                bus_req_i,
    input  logic                                bus_we_i,
    input  logic [periph_pkg::BusAddrWidth-1:0] bus_addr_i,
    input  logic [periph_pkg::BusDataWidth-1:0] bus_wdata_i,
    output logic [periph_pkg::BusDataWidth-1:0] bus_rdata_o,
    output logic                                bus_ready_o,
    output logic                                bus_err_o,
    input  logic [3:0]                          ext_irq_i,
    output logic                                irq_o,
    output logic                                tx_o
);
    import periph_pkg::*;

    logic                    sel_irq, sel_timer, sel_uart, we;
    logic [5:0]              word;
    logic [BusDataWidth-1:0] wdata, irq_rdata, timer_rdata, uart_rdata;
    logic [NumSources-1:0]   sources;
    logic [1:0]              timer_irq;
    logic                    uart_irq;

    // ------------------------------------------------------------------------
    // Decoder and interrupt controller
    // ------------------------------------------------------------------------
    periph_decoder #(.InclUart(InclUart), .InclTimer(InclTimer)) i_decoder (
        .clk_i, .rst_n_i, .bus_req_i, .bus_we_i, .bus_addr_i, .bus_wdata_i,
        .bus_rdata_o, .bus_ready_o, .bus_err_o,
        .sel_irq_o     ( sel_irq     ),
        .sel_timer_o   ( sel_timer   ),
        .sel_uart_o    ( sel_uart    ),
        .we_o          ( we          ),
        .word_o        ( word        ),
        .wdata_o       ( wdata       ),
        .irq_rdata_i   ( irq_rdata   ),
        .timer_rdata_i ( timer_rdata ),
        .uart_rdata_i  ( uart_rdata  )
    );

    assign sources = {ext_irq_i, timer_irq, uart_irq, 1'b0}; // Source 0 means none

    irq_controller i_irq (
        .clk_i, .rst_n_i, .sel_i(sel_irq), .we_i(we), .word_i(word), .wdata_i(wdata),
        .rdata_o(irq_rdata), .sources_i(sources), .irq_o
    );

    // ------------------------------------------------------------------------
    // Optional peers
    // ------------------------------------------------------------------------
    if (InclTimer) begin : gen_timer
        logic [TimerCnt-1:0] chan_irq;
        periph_timer #(.TimerCnt(TimerCnt)) i_timer (
            .clk_i, .rst_n_i, .sel_i(sel_timer), .we_i(we), .word_i(word), .wdata_i(wdata),
            .rdata_o(timer_rdata), .timer_irq_o(chan_irq)
        );
        assign timer_irq = 2'(chan_irq); // Single channel leaves source 3 low
    end else begin : gen_no_timer
        assign timer_irq   = '0;
        assign timer_rdata = '0;
    end

    if (InclUart) begin : gen_uart
        uart_tx i_uart (
            .clk_i, .rst_n_i, .sel_i(sel_uart), .we_i(we), .word_i(word), .wdata_i(wdata),
            .rdata_o(uart_rdata), .tx_o, .uart_irq_o(uart_irq)
        );
    end else begin : gen_no_uart
        assign tx_o       = 1'b1; // Idle line
        assign uart_irq   = 1'b0;
        assign uart_rdata = '0;
    end

endmodule

`default_nettype wire

// ==== src/uart_tx.sv ====
// 8N1 transmit only, DIV clocks per bit with DIV at least 1; TXDATA writes while busy are dropped
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                sel_i,
    input  logic                                we_i,
    input  logic [5:0]                          word_i,
    input  logic [periph_pkg::BusDataWidth-1:0] wdata_i,
    output logic [periph_pkg::BusDataWidth-1:0] rdata_o,
    output logic                                tx_o,
    output logic                                uart_irq_o
);
    import periph_pkg::*;

    uart_state_e state_q;
    uart_reg_e   reg_sel;
    logic [15:0] div_q;
    logic [15:0] baud_cnt_q;
    logic [7:0]  shift_q;
    logic [2:0]  bit_cnt_q;
    logic        ie_q;
    logic        busy;
    logic        tick;
    logic        load;

    assign reg_sel    = uart_reg_e'(word_i);
    assign busy       = (state_q != UART_IDLE);
    assign tick       = (baud_cnt_q >= div_q - 16'd1); // Last cycle of the bit
    assign load       = sel_i && we_i && (reg_sel == UART_TXDATA) && !busy;
    assign uart_irq_o = ie_q & ~busy;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q    <= UART_IDLE;
            tx_o       <= 1'b1;
            div_q      <= 16'd1;
            baud_cnt_q <= '0;
            bit_cnt_q  <= '0;
            ie_q       <= 1'b0;
        end else begin
            if (sel_i && we_i && reg_sel == UART_DIV) div_q <= wdata_i[15:0];
            if (sel_i && we_i && reg_sel == UART_IE)  ie_q  <= wdata_i[0];
            baud_cnt_q <= (!busy || tick) ? '0 : baud_cnt_q + 16'd1;
            case (state_q)
                UART_IDLE: if (load) begin
                    state_q <= UART_START;
                    tx_o    <= 1'b0;
                end
                UART_START: if (tick) begin
                    state_q   <= UART_DATA;
                    tx_o      <= shift_q[0];
                    bit_cnt_q <= '0;
                end
                UART_DATA: if (tick) begin
                    if (bit_cnt_q == 3'd7) begin
                        state_q <= UART_STOP;
                        tx_o    <= 1'b1;
                    end else begin
                        tx_o      <= shift_q[1]; // LSB first
                        bit_cnt_q <= bit_cnt_q + 3'd1;
                    end
                end
                UART_STOP: if (tick) state_q <= UART_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            shift_q <= wdata_i[7:0];
        end else if (state_q == UART_DATA && tick) begin
            shift_q <= shift_q >> 1;
        end
    end

    always_comb begin
        rdata_o = '0;
        case (reg_sel)
            UART_DIV:    rdata_o[15:0] = div_q;
            UART_STATUS: rdata_o[0]    = busy;
            UART_IE:     rdata_o[0]    = ie_q;
            default: ; // TXDATA is write only
        endcase
    end

    a_idle_line_high: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (state_q == UART_IDLE) |-> tx_o);

endmodule

`default_nettype wire

// ==== src/periph_timer.sv ====
// TimerCnt of 1 or 2; counts wrap to 0 after reaching compare, match bit is sticky until cleared
`timescale 1ns/1ps
`default_nettype none

module periph_timer #(
    parameter int TimerCnt = 2
) (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                sel_i,
    input  logic                                we_i,
    input  logic [5:0]                          word_i,
    input  logic [periph_pkg::BusDataWidth-1:0] wdata_i,
    output logic [periph_pkg::BusDataWidth-1:0] rdata_o,
    output logic [TimerCnt-1:0]                 timer_irq_o
);
    import periph_pkg::*;

    if (TimerCnt < 1 || TimerCnt > 2) begin : gen_cnt_check
        $fatal(1, "TimerCnt must be 1 or 2");
    end

    logic [TimerCnt-1:0]     enable_q;
    logic [TimerCnt-1:0]     match_q;
    logic [BusDataWidth-1:0] count_q   [TimerCnt];
    logic [BusDataWidth-1:0] compare_q [TimerCnt];
    logic [TimerCnt-1:0]     wr_chan;
    logic [TimerCnt-1:0]     hit;
    logic [3:0]              chan;
    timer_reg_e              reg_sel;

    assign chan        = word_i[5:2];
    assign reg_sel     = timer_reg_e'(word_i[1:0]);
    assign timer_irq_o = match_q;

    always_comb begin
        for (int c = 0; c < TimerCnt; c++) begin
            wr_chan[c] = sel_i && we_i && (chan == c);
            hit[c]     = enable_q[c] && (count_q[c] == compare_q[c]);
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            enable_q <= '0;
            match_q  <= '0;
            for (int c = 0; c < TimerCnt; c++) begin
                count_q[c] <= '0;
            end
        end else begin
            for (int c = 0; c < TimerCnt; c++) begin
                if (wr_chan[c] && reg_sel == TMR_CTRL) enable_q[c] <= wdata_i[0];
                if (wr_chan[c] && reg_sel == TMR_COUNT) begin
                    count_q[c] <= wdata_i; // Bus write beats counting
                end else if (hit[c]) begin
                    count_q[c] <= '0;
                end else if (enable_q[c]) begin
                    count_q[c] <= count_q[c] + 1'b1;
                end
                if (hit[c]) begin
                    match_q[c] <= 1'b1;
                end else if (wr_chan[c] && reg_sel == TMR_STATUS && wdata_i[0]) begin
                    match_q[c] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int c = 0; c < TimerCnt; c++) begin
            if (wr_chan[c] && reg_sel == TMR_COMPARE) compare_q[c] <= wdata_i;
        end
    end

    // Unimplemented channels read as zero
    always_comb begin
        rdata_o = '0;
        for (int c = 0; c < TimerCnt; c++) begin
            if (chan == c) begin
                case (reg_sel)
                    TMR_CTRL:    rdata_o = {{(BusDataWidth-1){1'b0}}, enable_q[c]};
                    TMR_COUNT:   rdata_o = count_q[c];
                    TMR_COMPARE: rdata_o = compare_q[c];
                    TMR_STATUS:  rdata_o = {{(BusDataWidth-1){1'b0}}, match_q[c]};
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/irq_controller.sv ====
// Level sources only, one target; source 0 unused; UART=1, timers=2,3, external lines=4..7
`timescale 1ns/1ps
`default_nettype none

module irq_controller (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                sel_i,
    input  logic                                we_i,
    input  logic [5:0]                          word_i,
    input  logic [periph_pkg::BusDataWidth-1:0] wdata_i,
    output logic [periph_pkg::BusDataWidth-1:0] rdata_o,
    input  logic [periph_pkg::NumSources-1:0]   sources_i,
    output logic                                irq_o
);
    import periph_pkg::*;

    localparam int IdWidth = $clog2(NumSources);

    logic [PrioWidth-1:0]  prio_q [NumSources];
    logic [NumSources-1:0] enable_q;
    logic [NumSources-1:0] in_service_q;
    logic [NumSources-1:0] pending;
    logic [PrioWidth-1:0]  threshold_q;
    logic [PrioWidth-1:0]  best_prio;
    logic [IdWidth-1:0]    best_id;
    logic                  found;
    logic                  claim_rd;
    irq_reg_e              reg_sel;

    assign reg_sel  = irq_reg_e'(word_i);
    assign pending  = sources_i & ~in_service_q;
    assign claim_rd = sel_i & ~we_i & (reg_sel == IRQ_CLAIM);

    // ------------------------------------------------------------------------
    // Candidate search, strict compare keeps the lowest ID on a tie
    // ------------------------------------------------------------------------
    always_comb begin
        found     = 1'b0;
        best_id   = '0;
        best_prio = threshold_q;
        for (int i = 1; i < NumSources; i++) begin
            if (pending[i] && enable_q[i] && (prio_q[i] > best_prio)) begin
                found     = 1'b1;
                best_id   = IdWidth'(i);
                best_prio = prio_q[i];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NumSources; i++) begin
                prio_q[i] <= '0;
            end
            enable_q     <= '0;
            threshold_q  <= '0;
            in_service_q <= '0;
            irq_o        <= 1'b0;
        end else begin
            irq_o <= found;
            if (sel_i && we_i) begin
                case (reg_sel)
                    IRQ_PRIO0, IRQ_PRIO1, IRQ_PRIO2, IRQ_PRIO3,
                    IRQ_PRIO4, IRQ_PRIO5, IRQ_PRIO6, IRQ_PRIO7:
                        prio_q[word_i[IdWidth-1:0]] <= wdata_i[PrioWidth-1:0];
                    IRQ_ENABLE:    enable_q    <= wdata_i[NumSources-1:0];
                    IRQ_THRESHOLD: threshold_q <= wdata_i[PrioWidth-1:0];
                    IRQ_CLAIM: begin // Complete
                        if (wdata_i < NumSources) in_service_q[wdata_i[IdWidth-1:0]] <= 1'b0;
                    end
                    default: ;
                endcase
            end
            if (claim_rd && found) in_service_q[best_id] <= 1'b1;
        end
    end

    always_comb begin
        rdata_o = '0;
        case (reg_sel)
            IRQ_PRIO0, IRQ_PRIO1, IRQ_PRIO2, IRQ_PRIO3,
            IRQ_PRIO4, IRQ_PRIO5, IRQ_PRIO6, IRQ_PRIO7:
                rdata_o[PrioWidth-1:0] = prio_q[word_i[IdWidth-1:0]];
            IRQ_ENABLE:    rdata_o[NumSources-1:0] = enable_q;
            IRQ_THRESHOLD: rdata_o[PrioWidth-1:0]  = threshold_q;
            IRQ_PENDING:   rdata_o[NumSources-1:0] = pending;
            IRQ_CLAIM:     rdata_o[IdWidth-1:0]    = best_id; // 0 when nothing qualifies
            default: ;
        endcase
    end

    // Claimed source is valid and held in service afterwards
    a_claim_in_service: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (claim_rd && found) |=> ($past(best_id) < NumSources) && in_service_q[$past(best_id)]);

endmodule

`default_nettype wire

// ==== src/periph_decoder.sv ====
// Single master, fixed one-cycle response; absent or excluded slots return ErrorFill with error
`timescale 1ns/1ps
`default_nettype none

module periph_decoder #(
    parameter bit InclUart  = 1,
    parameter bit InclTimer = 1
) (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                bus_req_i,
    input  logic                                bus_we_i,
    input  logic [periph_pkg::BusAddrWidth-1:0] bus_addr_i,
    input  logic [periph_pkg::BusDataWidth-1:0] bus_wdata_i,
    output logic [periph_pkg::BusDataWidth-1:0] bus_rdata_o,
    output logic                                bus_ready_o,
    output logic                                bus_err_o,
    output logic                                sel_irq_o,
    output logic                                sel_timer_o,
    output logic                                sel_uart_o,
    output logic                                we_o,
    output logic [5:0]                          word_o,
    output logic [periph_pkg::BusDataWidth-1:0] wdata_o,
    input  logic [periph_pkg::BusDataWidth-1:0] irq_rdata_i,
    input  logic [periph_pkg::BusDataWidth-1:0] timer_rdata_i,
    input  logic [periph_pkg::BusDataWidth-1:0] uart_rdata_i
);
    import periph_pkg::*;

    localparam int SlotBits = $clog2(NumSlots);

    logic                    accept;
    logic                    hit;
    slot_e                   slot;
    logic [BusDataWidth-1:0] rdata_mux;

    assign accept  = bus_req_i & ~bus_ready_o; // No new request during the ready pulse
    assign slot    = slot_e'(bus_addr_i[SlotShift +: SlotBits]);
    assign we_o    = bus_we_i;
    assign word_o  = bus_addr_i[SlotShift-1:2];
    assign wdata_o = bus_wdata_i;

    always_comb begin
        sel_irq_o   = 1'b0;
        sel_timer_o = 1'b0;
        sel_uart_o  = 1'b0;
        hit         = 1'b0;
        rdata_mux   = ErrorFill;
        case (slot)
            SLOT_IRQ: begin
                hit       = 1'b1;
                sel_irq_o = accept;
                rdata_mux = irq_rdata_i;
            end
            SLOT_TIMER: if (InclTimer) begin
                hit         = 1'b1;
                sel_timer_o = accept;
                rdata_mux   = timer_rdata_i;
            end
            SLOT_UART: if (InclUart) begin
                hit        = 1'b1;
                sel_uart_o = accept;
                rdata_mux  = uart_rdata_i;
            end
            default: ; // SPI, Ethernet and unmapped slots
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            bus_ready_o <= 1'b0;
            bus_err_o   <= 1'b0;
        end else begin
            bus_ready_o <= accept;
            bus_err_o   <= accept & ~hit;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) bus_rdata_o <= rdata_mux;
    end

    a_err_with_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        bus_err_o |-> bus_ready_o);

endmodule

`default_nettype wire

// ==== src/periph_pkg.sv ====
// Register map and widths for the peripheral bus; slot numbers above SLOT_ETH are absent
`default_nettype none

package periph_pkg;

    // ------------------------------------------------------------------------
    // Bus geometry
    // ------------------------------------------------------------------------
    localparam int BusAddrWidth = 12;
    localparam int BusDataWidth = 32;
    localparam int SlotShift    = 8;   // Slot in addr[11:8], word in addr[7:2]
    localparam int NumSlots     = 16;

    localparam logic [BusDataWidth-1:0] ErrorFill = 32'hdeadbeef;

    typedef enum logic [3:0] {
        SLOT_IRQ   = 4'd0,
        SLOT_TIMER = 4'd1,
        SLOT_UART  = 4'd2,
        SLOT_SPI   = 4'd3,
        SLOT_ETH   = 4'd4
    } slot_e;

    // ------------------------------------------------------------------------
    // Interrupt controller
    // ------------------------------------------------------------------------
    localparam int NumSources  = 8;   // ID 0 is reserved for "none"
    localparam int MaxPriority = 7;
    localparam int PrioWidth   = $clog2(MaxPriority + 1);

    typedef enum logic [5:0] {
        IRQ_PRIO0     = 6'd0,
        IRQ_PRIO1     = 6'd1,
        IRQ_PRIO2     = 6'd2,
        IRQ_PRIO3     = 6'd3,
        IRQ_PRIO4     = 6'd4,
        IRQ_PRIO5     = 6'd5,
        IRQ_PRIO6     = 6'd6,
        IRQ_PRIO7     = 6'd7,
        IRQ_ENABLE    = 6'd8,
        IRQ_THRESHOLD = 6'd9,
        IRQ_PENDING   = 6'd10,
        IRQ_CLAIM     = 6'd11
    } irq_reg_e;

    // Per channel, channel N starts at word N*4
    typedef enum logic [1:0] {TMR_CTRL, TMR_COUNT, TMR_COMPARE, TMR_STATUS} timer_reg_e;

    typedef enum logic [5:0] {
        UART_DIV    = 6'd0,
        UART_TXDATA = 6'd1,
        UART_STATUS = 6'd2,
        UART_IE     = 6'd3
    } uart_reg_e;

    typedef enum logic [1:0] {UART_IDLE, UART_START, UART_DATA, UART_STOP} uart_state_e;

endpackage

`default_nettype wire
